/* cache_pkg.sv */
`default_nettype none

package cache_pkg;

  // Processor port and line geometry
  localparam int ADDR_W     = 32;
  localparam int WORD_W     = 32;
  localparam int LINE_WORDS = 4;
  localparam int OFFSET_W   = 4;

  // Word 0 sits in the low bits
  typedef logic [LINE_WORDS-1:0][WORD_W-1:0] line_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic [WORD_W-1:0] wdata;
  } cache_req_t;

  typedef struct packed {
    logic [WORD_W-1:0] rdata;
    logic              hit;
  } cache_resp_t;

  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } mem_op_e;

  // Line address is the byte address without the in-line offset
  typedef struct packed {
    logic [ADDR_W-OFFSET_W-1:0] line_addr;
    mem_op_e                    op;
    line_t                      data;
  } mem_req_t;

  typedef enum logic [2:0] {
    IDLE      = 3'd0,
    LOOKUP    = 3'd1,
    WRITEBACK = 3'd2,
    REFILL    = 3'd3,
    RESPOND   = 3'd4
  } ctrl_state_e;

endpackage

`default_nettype wire

/* tag_store.sv */
`timescale 1ns/1ns
`default_nettype none

module tag_store import cache_pkg::*; #(
  parameter int NUM_SETS = 8,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W
) (
  input  wire              clk,
  input  wire              reset,
  input  wire              lookup,
  input  wire [IDX_W-1:0]  index,
  output logic [TAG_W-1:0] rd_tag,
  output logic             rd_valid,
  output logic             rd_dirty,
  input  wire              wr_en,
  input  wire [TAG_W-1:0]  wr_tag,
  input  wire              wr_valid,
  input  wire              wr_dirty
);

  logic [TAG_W-1:0]    tags [NUM_SETS];
  logic [NUM_SETS-1:0] valid_bits;
  logic [NUM_SETS-1:0] dirty_bits;

  // Tag written on every update
  always_ff @(posedge clk) begin
    if (wr_en) begin
      tags[index] <= wr_tag;
    end
  end

  // Status bits per set
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
      dirty_bits <= '0;
    end else if (wr_en) begin
      valid_bits[index] <= wr_valid;
      dirty_bits[index] <= wr_dirty;
    end
  end

  // Registered lookup that holds until the next strobe
  always_ff @(posedge clk) begin
    if (lookup) begin
      rd_tag <= tags[index];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_valid <= 1'b0;
      rd_dirty <= 1'b0;
    end else if (lookup) begin
      rd_valid <= valid_bits[index];
      rd_dirty <= dirty_bits[index];
    end
  end

  // Controller never reads and updates a set in the same cycle
  a_no_lookup_during_update: assert property (
    @(posedge clk) disable iff (reset) !(lookup && wr_en)
  ) else $error("tag_store: lookup and update in the same cycle");

endmodule

`default_nettype wire

/* line_store.sv */
`timescale 1ns/1ns
`default_nettype none

module line_store import cache_pkg::*; #(
  parameter int NUM_SETS = 8,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int SEL_W = $clog2(LINE_WORDS)
) (
  input  wire              clk,
  input  wire              lookup,
  input  wire [IDX_W-1:0]  index,
  output line_t            rd_line,
  input  wire              fill_en,
  input  wire line_t       fill_line,
  input  wire              word_en,
  input  wire [SEL_W-1:0]  word_sel,
  input  wire [WORD_W-1:0] word_data
);

  line_t lines [NUM_SETS];

  // Refill replaces the line and a write hit touches one word only
  always_ff @(posedge clk) begin
    if (fill_en) begin
      lines[index] <= fill_line;
    end else if (word_en) begin
      lines[index][word_sel] <= word_data;
    end
  end

  // Registered line read
  always_ff @(posedge clk) begin
    if (lookup) begin
      rd_line <= lines[index];
    end
  end

  // Refill and write hit come from different controller states
  a_fill_word_exclusive: assert property (
    @(posedge clk) fill_en |-> !word_en
  ) else $error("line_store: refill and word write in the same cycle");

endmodule

`default_nettype wire

/* cache_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_ctrl import cache_pkg::*; #(
  parameter int NUM_SETS = 8,
  localparam int IDX_W = $clog2(NUM_SETS),
  localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W,
  localparam int SEL_W = $clog2(LINE_WORDS)
) (
  input  wire               clk,
  input  wire               reset,
  // Processor side
  input  wire               req_valid,
  output logic              req_ready,
  input  wire cache_req_t   req,
  output logic              resp_valid,
  input  wire               resp_ready,
  output cache_resp_t       resp,
  // Shared store addressing
  output logic              lookup,
  output logic [IDX_W-1:0]  index,
  // Tag store
  input  wire [TAG_W-1:0]   rd_tag,
  input  wire               rd_valid,
  input  wire               rd_dirty,
  output logic              wr_en,
  output logic [TAG_W-1:0]  wr_tag,
  output logic              wr_valid,
  output logic              wr_dirty,
  // Line store
  input  wire line_t        rd_line,
  output logic              fill_en,
  output line_t             fill_line,
  output logic              word_en,
  output logic [SEL_W-1:0]  word_sel,
  output logic [WORD_W-1:0] word_data,
  // Memory
  output logic              mem_req_valid,
  input  wire               mem_req_ready,
  output mem_req_t          mem_req,
  input  wire               mem_resp_valid,
  input  wire line_t        mem_rdata
);

  ctrl_state_e      state;
  ctrl_state_e      state_next;
  cache_req_t       req_q;
  cache_resp_t      resp_q;
  logic             mem_pending;
  logic [IDX_W-1:0] req_index;
  logic [TAG_W-1:0] req_tag;
  logic [SEL_W-1:0] req_word;
  logic             hit;
  line_t            refill_line;

  // Address fields of the request in flight
  assign req_index = req_q.addr[OFFSET_W +: IDX_W];
  assign req_tag   = req_q.addr[ADDR_W-1 -: TAG_W];
  assign req_word  = req_q.addr[OFFSET_W-1 -: SEL_W];

  assign req_ready  = (state == IDLE);
  assign resp_valid = (state == RESPOND);
  assign resp       = resp_q;

  // Stores are strobed with the incoming address on acceptance
  assign lookup = req_valid && req_ready;
  assign index  = req_ready ? req.addr[OFFSET_W +: IDX_W] : req_index;

  assign hit = rd_valid && (rd_tag == req_tag);

  // Refilled line with a pending write merged in
  always_comb begin
    refill_line = mem_rdata;
    if (req_q.write) begin
      refill_line[req_word] = req_q.wdata;
    end
  end

  assign word_en   = (state == LOOKUP) && hit && req_q.write;
  assign word_sel  = req_word;
  assign word_data = req_q.wdata;
  assign fill_en   = (state == REFILL) && mem_resp_valid;
  assign fill_line = refill_line;

  // Write hit or refill updates the tag and takes dirty from the access type
  assign wr_en    = word_en || fill_en;
  assign wr_tag   = req_tag;
  assign wr_valid = 1'b1;
  assign wr_dirty = req_q.write;

  // Victim line and tag stay in the store read registers until next lookup
  assign mem_req_valid = ((state == WRITEBACK) || (state == REFILL)) && !mem_pending;

  always_comb begin
    mem_req.op        = (state == WRITEBACK) ? OP_WRITE : OP_READ;
    mem_req.line_addr = (state == WRITEBACK) ? {rd_tag, req_index} : {req_tag, req_index};
    mem_req.data      = rd_line;
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (lookup) begin
          state_next = LOOKUP;
        end
      end
      LOOKUP: begin
        if (hit) begin
          state_next = RESPOND;
        end else if (rd_valid && rd_dirty) begin
          state_next = WRITEBACK;
        end else begin
          state_next = REFILL;
        end
      end
      WRITEBACK: begin
        if (mem_resp_valid) begin
          state_next = REFILL;
        end
      end
      REFILL: begin
        if (mem_resp_valid) begin
          state_next = RESPOND;
        end
      end
      RESPOND: begin
        if (resp_ready) begin
          state_next = IDLE;
        end
      end
      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= IDLE;
      mem_pending <= 1'b0;
    end else begin
      state <= state_next;
      if (mem_req_valid && mem_req_ready) begin
        mem_pending <= 1'b1;
      end else if (mem_resp_valid) begin
        mem_pending <= 1'b0;
      end
    end
  end

  // Request latch and response register
  always_ff @(posedge clk) begin
    if (lookup) begin
      req_q <= req;
    end
    if ((state == LOOKUP) && hit) begin
      resp_q.rdata <= req_q.write ? req_q.wdata : rd_line[req_word];
      resp_q.hit   <= 1'b1;
    end else if (fill_en) begin
      resp_q.rdata <= refill_line[req_word];
      resp_q.hit   <= 1'b0;
    end
  end

  // A stalled response stays up and unchanged until it transfers
  a_resp_held: assert property (
    @(posedge clk) disable iff (reset)
    (resp_valid && !resp_ready) |=> (resp_valid && $stable(resp))
  ) else $error("cache_ctrl: response changed or dropped under back-pressure");

  // Memory request holds while the memory is not ready
  a_mem_req_stable: assert property (
    @(posedge clk) disable iff (reset)
    (mem_req_valid && !mem_req_ready) |=> $stable(mem_req)
  ) else $error("cache_ctrl: memory request changed before acceptance");

endmodule

`default_nettype wire

/* backing_mem.sv */
`timescale 1ns/1ns
`default_nettype none

module backing_mem import cache_pkg::*; #(
  parameter int MEM_LINES   = 4096,
  parameter int MEM_LATENCY = 4,
  localparam int MEM_AW = $clog2(MEM_LINES),
  localparam int CNT_W  = $clog2(MEM_LATENCY + 1)
) (
  input  wire           clk,
  input  wire           reset,
  input  wire           mem_req_valid,
  output logic          mem_req_ready,
  input  wire mem_req_t mem_req,
  output logic          mem_resp_valid,
  output line_t         mem_rdata
);

  // Zero from time zero and untouched by reset
  line_t ram [MEM_LINES] = '{default: '0};

  logic              busy;
  logic [CNT_W-1:0]  count;
  mem_req_t          req_q;
  logic [MEM_AW-1:0] line_idx;
  logic              access;

  assign mem_req_ready = !busy;

  // Line address wraps onto the RAM depth
  assign line_idx = req_q.line_addr[MEM_AW-1:0];
  assign access   = busy && (count == '0);

  // Latency counter with a response pulse on expiry
  always_ff @(posedge clk) begin
    if (reset) begin
      busy           <= 1'b0;
      count          <= '0;
      mem_resp_valid <= 1'b0;
    end else begin
      mem_resp_valid <= 1'b0;
      if (!busy) begin
        if (mem_req_valid) begin
          busy  <= 1'b1;
          count <= CNT_W'(MEM_LATENCY - 1);
        end
      end else if (count == '0) begin
        busy           <= 1'b0;
        mem_resp_valid <= 1'b1;
      end else begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req_valid && mem_req_ready) begin
      req_q <= mem_req;
    end
  end

  // The access itself happens on the expiring edge
  always @(posedge clk) begin
    if (access) begin
      if (req_q.op == OP_WRITE) begin
        ram[line_idx] <= req_q.data;
      end
      mem_rdata <= ram[line_idx];
    end
  end

  a_no_req_while_busy: assert property (
    @(posedge clk) disable iff (reset) busy |-> !mem_req_valid
  ) else $error("backing_mem: request issued while busy");

endmodule

`default_nettype wire

/* cache_top.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_top import cache_pkg::*; #(
  parameter int NUM_SETS    = 8,
  parameter int MEM_LATENCY = 4
) (
  input  wire             clk,
  input  wire             reset,
  input  wire             req_valid,
  output logic            req_ready,
  input  wire cache_req_t req,
  output logic            resp_valid,
  input  wire             resp_ready,
  output cache_resp_t     resp
);

  localparam int IDX_W     = $clog2(NUM_SETS);
  localparam int TAG_W     = ADDR_W - OFFSET_W - IDX_W;
  localparam int SEL_W     = $clog2(LINE_WORDS);
  // Backing RAM depth in lines
  localparam int MEM_LINES = 4096;

  logic              lookup;
  logic [IDX_W-1:0]  index;
  logic [TAG_W-1:0]  rd_tag;
  logic              rd_valid;
  logic              rd_dirty;
  logic              wr_en;
  logic [TAG_W-1:0]  wr_tag;
  logic              wr_valid;
  logic              wr_dirty;
  line_t             rd_line;
  logic              fill_en;
  line_t             fill_line;
  logic              word_en;
  logic [SEL_W-1:0]  word_sel;
  logic [WORD_W-1:0] word_data;
  logic              mem_req_valid;
  logic              mem_req_ready;
  mem_req_t          mem_req;
  logic              mem_resp_valid;
  line_t             mem_rdata;

  tag_store #(.NUM_SETS(NUM_SETS)) u_tag_store (
    .clk, .reset, .lookup, .index, .rd_tag, .rd_valid, .rd_dirty,
    .wr_en, .wr_tag, .wr_valid, .wr_dirty
  );

  line_store #(.NUM_SETS(NUM_SETS)) u_line_store (
    .clk, .lookup, .index, .rd_line, .fill_en, .fill_line,
    .word_en, .word_sel, .word_data
  );

  cache_ctrl #(.NUM_SETS(NUM_SETS)) u_cache_ctrl (
    .clk, .reset,
    .req_valid, .req_ready, .req, .resp_valid, .resp_ready, .resp,
    .lookup, .index,
    .rd_tag, .rd_valid, .rd_dirty, .wr_en, .wr_tag, .wr_valid, .wr_dirty,
    .rd_line, .fill_en, .fill_line, .word_en, .word_sel, .word_data,
    .mem_req_valid, .mem_req_ready, .mem_req, .mem_resp_valid, .mem_rdata
  );

  backing_mem #(
    .MEM_LINES  (MEM_LINES),
    .MEM_LATENCY(MEM_LATENCY)
  ) u_backing_mem (
    .clk, .reset, .mem_req_valid, .mem_req_ready, .mem_req,
    .mem_resp_valid, .mem_rdata
  );

endmodule

`default_nettype wire

/* cache_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module cache_checker import cache_pkg::*; (
  input  wire              clk,
  input  wire              reset,
  input  wire              req_valid,
  input  wire              req_ready,
  input  wire cache_req_t  req,
  input  wire              resp_valid,
  input  wire              resp_ready,
  input  wire cache_resp_t resp,
  input  wire [WORD_W-1:0] exp_rdata,
  input  wire              exp_hit,
  output int               value_errors,
  output int               timing_errors,
  output int               protocol_errors,
  output int               resp_count
);

  int                cycle;
  int                accept_cycle;
  logic              pending;
  logic              resp_seen;
  logic              held;
  logic              fresh;
  cache_resp_t       held_resp;
  logic [ADDR_W-1:0] req_addr;

  // Sampled on the rising edge while inputs change on the falling edge
  always @(posedge clk) begin
    if (reset) begin
      cycle = 0;
      accept_cycle = 0;
      pending = 1'b0;
      resp_seen = 1'b0;
      held = 1'b0;
      fresh = 1'b1;
      value_errors = 0;
      timing_errors = 0;
      protocol_errors = 0;
      resp_count = 0;
    end else begin
      cycle++;
      if (fresh && (!req_ready || resp_valid)) begin
        protocol_errors++;
        $display("cache not idle after reset: req_ready %b, resp_valid %b",
                 req_ready, resp_valid);
      end
      fresh = 1'b0;
      if (resp_valid && req_ready) begin
        protocol_errors++;
        $display("req_ready high while a response is pending");
      end
      // A stalled response stays up and unchanged
      if (held && !resp_valid) begin
        protocol_errors++;
        $display("resp_valid dropped before the response transferred");
      end else if (held && (resp !== held_resp)) begin
        value_errors++;
        $display("mismatch resp under back-pressure: expected %h, got %h", held_resp, resp);
      end
      if (resp_valid && !resp_seen) begin
        resp_seen = 1'b1;
        if (!pending) begin
          protocol_errors++;
          $display("response without an accepted request");
        end else if (exp_hit && (cycle - accept_cycle != 2)) begin
          timing_errors++;
          $display("hit response came %0d cycles after acceptance instead of 2",
                   cycle - accept_cycle);
        end
      end
      if (resp_valid && resp_ready) begin
        resp_count++;
        pending = 1'b0;
        resp_seen = 1'b0;
        if (resp.rdata !== exp_rdata) begin
          value_errors++;
          $display("mismatch rdata at addr %h: expected %h, got %h",
                   req_addr, exp_rdata, resp.rdata);
        end
        if (resp.hit !== exp_hit) begin
          value_errors++;
          $display("mismatch hit at addr %h: expected %h, got %h", req_addr, exp_hit, resp.hit);
        end
      end
      held = resp_valid && !resp_ready;
      held_resp = resp;
      if (req_valid && req_ready) begin
        pending = 1'b1;
        accept_cycle = cycle;
        req_addr = req.addr;
      end
    end
  end

endmodule

`default_nettype wire

/* tb_cache.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_cache import cache_pkg::*; ();

  localparam int NUM_SETS    = 8;
  localparam int MEM_LATENCY = 4;
  localparam int NUM_REQS    = 400;
  localparam int CLK_PERIOD  = 4;
  localparam int IDX_W       = $clog2(NUM_SETS);
  localparam int TAG_W       = ADDR_W - OFFSET_W - IDX_W;
  localparam logic [31:0] SEED = 32'h513a_b29f;
  // Worst request covers idle gap, writeback, refill and a stalled response
  localparam int WATCHDOG_CYCLES = NUM_REQS * (2 * MEM_LATENCY + 24) + 200;

  logic                clk;
  logic                reset;
  logic                req_valid;
  logic                req_ready;
  cache_req_t          req;
  logic                resp_valid;
  logic                resp_ready;
  cache_resp_t         resp;
  logic [WORD_W-1:0]   exp_rdata;
  logic                exp_hit;
  int                  value_errors;
  int                  timing_errors;
  int                  protocol_errors;
  int                  resp_count;
  logic [31:0]         stim_rng;
  logic [31:0]         bp_rng;
  // Reference model of flat word memory plus shadow tags per set
  logic [WORD_W-1:0]   model_mem [256];
  logic [TAG_W-1:0]    shadow_tag [NUM_SETS];
  logic [NUM_SETS-1:0] shadow_valid;

  cache_top #(.NUM_SETS(NUM_SETS), .MEM_LATENCY(MEM_LATENCY)) uut (
    .clk, .reset, .req_valid, .req_ready, .req, .resp_valid, .resp_ready, .resp
  );

  cache_checker u_checker (
    .clk, .reset, .req_valid, .req_ready, .req, .resp_valid, .resp_ready, .resp,
    .exp_rdata, .exp_hit, .value_errors, .timing_errors, .protocol_errors, .resp_count
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic report_counts();
    $display("errors: value %0d, timing %0d, protocol %0d; responses %0d of %0d",
             value_errors, timing_errors, protocol_errors, resp_count, NUM_REQS);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // resp_ready low about one cycle in four from its own stream of the same seed
  initial begin
    resp_ready = 1'b0;
    bp_rng = {SEED[15:0], SEED[31:16]};
    forever begin
      @(negedge clk);
      bp_rng = xorshift(bp_rng);
      resp_ready = (bp_rng[1:0] != 2'b00);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired at %0t before all responses arrived", $time);
    report_counts();
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    int               widx;
    int               set_idx;
    logic [TAG_W-1:0] tag;
    reset = 1'b1;
    req_valid = 1'b0;
    req = '0;
    exp_rdata = '0;
    exp_hit = 1'b0;
    stim_rng = SEED;
    shadow_valid = '0;
    for (int a = 0; a < 256; a++) begin
      model_mem[a] = '0;
    end
    repeat (5) @(negedge clk);
    reset = 1'b0;
    for (int i = 0; i < NUM_REQS; i++) begin
      stim_rng = xorshift(stim_rng);
      repeat (stim_rng[8:7]) @(negedge clk);
      // Four tags over four sets keep conflicts and evictions frequent
      req.addr = '0;
      req.addr[ADDR_W-1 -: TAG_W] = TAG_W'(stim_rng[1:0]);
      req.addr[OFFSET_W +: IDX_W] = IDX_W'(stim_rng[3:2]);
      req.addr[OFFSET_W-1:2] = stim_rng[5:4];
      req.write = stim_rng[6];
      stim_rng = xorshift(stim_rng);
      req.wdata = stim_rng;
      req_valid = 1'b1;
      while (!req_ready) @(negedge clk);
      @(negedge clk);
      req_valid = 1'b0;
      // Request accepted on the last rising edge
      set_idx = int'(req.addr[OFFSET_W +: IDX_W]);
      tag = req.addr[ADDR_W-1 -: TAG_W];
      widx = int'(req.addr[9:2]);
      exp_hit = shadow_valid[set_idx] && (shadow_tag[set_idx] == tag);
      shadow_valid[set_idx] = 1'b1;
      shadow_tag[set_idx] = tag;
      if (req.write) begin
        model_mem[widx] = req.wdata;
      end
      exp_rdata = model_mem[widx];
    end
    wait (resp_count == NUM_REQS);
    @(negedge clk);
    report_counts();
    if (value_errors + timing_errors + protocol_errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* cache_sys.f */
cache_pkg.sv
tag_store.sv
line_store.sv
cache_ctrl.sv
backing_mem.sv
cache_top.sv
cache_checker.sv
tb_cache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_cache \
  -f cache_sys.f -Mdir obj_dir -o tb_cache
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_cache > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TEST FAILED" sim.log; then
  exit 1
fi
exit 0
